//--- sim.f
src/spi_pkg.sv
src/spi_peripheral.sv
src/command_decoder.sv
src/register_file.sv
src/checksum_unit.sv
src/spi_subsystem_top.sv
sim/spi_subsystem_checker.sv
sim/spi_subsystem_tb.sv

//--- sim/spi_subsystem_checker.sv
/*
 * Concurrent assertions on the internal valids and enables
 * Bound into the subsystem top level
 */

`timescale 1ns/1ps

module spi_subsystem_checker (
    input logic                    clock_in,
    input logic                    reset_n_in,
    input logic                    spi_select_in,
    input logic                    spi_data_out,
    input logic                    operand_valid,
    input logic                    response_1_valid,
    input logic                    response_2_valid,
    input logic                    response_3_valid,
    input logic                    reg_write_active,
    input logic                    reg_read_active,
    input logic                    checksum_feed_active,
    input logic                    checksum_read_active,
    input spi_pkg::decoder_state_t decoder_state
);

    import spi_pkg::*;

    // Number of assertion failures so far
    int failure_count = 0;

    // Only one sub-peripheral answers at a time
    response_onehot: assert property (@(posedge clock_in) disable iff (!reset_n_in)
        $onehot0({response_1_valid, response_2_valid, response_3_valid}))
    else begin
        failure_count++;
        $error("More than one response valid is high");
    end

    // One pulse per received operand byte
    operand_pulse: assert property (@(posedge clock_in) disable iff (!reset_n_in)
        operand_valid |=> !operand_valid)
    else begin
        failure_count++;
        $error("operand_valid is high for more than one cycle");
    end

    // Decoder enables nothing between transactions
    idle_no_enable: assert property (@(posedge clock_in) disable iff (!reset_n_in)
        (decoder_state == IDLE) |-> !(reg_write_active || reg_read_active ||
                                      checksum_feed_active || checksum_read_active))
    else begin
        failure_count++;
        $error("An enable is high while the decoder is idle");
    end

    // Data line quiet while deselected
    quiet_when_deselected: assert property (@(posedge clock_in) disable iff (!reset_n_in)
        spi_select_in |-> !spi_data_out)
    else begin
        failure_count++;
        $error("spi_data_out is high while select is high");
    end

endmodule

bind spi_subsystem_top spi_subsystem_checker checker_i (
    .clock_in             (clock_in),
    .reset_n_in           (reset_n_in),
    .spi_select_in        (spi_select_in),
    .spi_data_out         (spi_data_out),
    .operand_valid        (operand_valid),
    .response_1_valid     (response_1_valid),
    .response_2_valid     (response_2_valid),
    .response_3_valid     (response_3_valid),
    .reg_write_active     (reg_write_active),
    .reg_read_active      (reg_read_active),
    .checksum_feed_active (checksum_feed_active),
    .checksum_read_active (checksum_read_active),
    .decoder_state        (decoder_i.state)
);

//--- sim/spi_subsystem_tb.sv
/*
 * Testbench for the SPI command subsystem
 * Mode 0 SPI master driving a table of transactions
 * Model of the register bank and the checksum for expected responses
 */

`timescale 1ns/1ps

module spi_subsystem_tb;

    import spi_pkg::*;

    localparam int        HALF_PERIOD  = 10;
    localparam int        GAP_CYCLES   = 6;
    localparam int        RESET_CYCLES = 3;
    localparam int        MAX_ROWS     = 16;
    localparam int        MAX_OPS      = 9;
    localparam bit [31:0] RANDOM_SEED  = 32'h02de_0eae;

    // Byte returned on every operand of a chip ID transaction
    localparam byte_t     CHIP_ID_EXPECTED = 8'h81;

    logic clock_in;
    logic reset_n_in;
    logic spi_select_in;
    logic spi_clock_in;
    logic spi_data_in;
    logic spi_data_out;

    // Transaction table, one row per select-low period
    string row_name   [MAX_ROWS];
    byte_t row_opcode [MAX_ROWS];
    int    row_count  [MAX_ROWS];
    bit    row_reset  [MAX_ROWS];
    byte_t row_ops    [MAX_ROWS][MAX_OPS];
    byte_t row_expect [MAX_ROWS][MAX_OPS];
    int    row_total = 0;

    // Operands of the row under construction
    byte_t next_ops [MAX_OPS];

    // Expected DUT state
    byte_t model_regs [REG_COUNT];
    byte_t model_sum;

    int cycle_count = 0;
    int cycle_limit = 0;

    spi_subsystem_top dut_i (
        .clock_in      (clock_in),
        .reset_n_in    (reset_n_in),
        .spi_select_in (spi_select_in),
        .spi_clock_in  (spi_clock_in),
        .spi_data_in   (spi_data_in),
        .spi_data_out  (spi_data_out)
    );

    initial begin
        clock_in = 1'b0;
        forever #10 clock_in = ~clock_in;
    end

    always @(posedge clock_in) begin
        cycle_count <= cycle_count + 1;
        if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
            $display("Timeout: run still busy after %0d clock cycles", cycle_count);
            $display("TEST FAILED");
            $fatal(1, "Run stopped by the cycle limit");
        end else if (dut_i.checker_i.failure_count != 0) begin
            $display("Checker assertion failed by clock cycle %0d", cycle_count);
            $display("TEST FAILED");
            $fatal(1, "Assertion failure in the checker");
        end
    end

    task automatic check_byte(input string name, input byte_t expected, input byte_t actual);
        if (actual !== expected) begin
            $display("[FAIL] %s: expected %02h, actual %02h", name, expected, actual);
            $display("TEST FAILED");
            $fatal(1, "Response byte mismatch");
        end
    endtask

    task automatic clear_model();
        model_sum = '0;
        for (int i = 0; i < REG_COUNT; i++) begin
            model_regs[i] = '0;
        end
    endtask

    task automatic random_ops(input int first);
        for (int i = first; i < MAX_OPS; i++) begin
            next_ops[i] = byte_t'($urandom);
        end
    endtask

    // Stores a row and plays it through the model for its expected bytes
    task automatic add_row(input string name, input byte_t opcode, input int count,
                           input bit reset_before);
        reg_addr_t pointer;
        int        r;
        r = row_total;
        pointer = '0;
        if (reset_before) begin
            clear_model();
        end
        row_name[r]   = name;
        row_opcode[r] = opcode;
        row_count[r]  = count;
        row_reset[r]  = reset_before;
        for (int k = 0; k < count; k++) begin
            row_ops[r][k]    = next_ops[k];
            row_expect[r][k] = '0;
            case (opcode)
                OPCODE_CHIP_ID: row_expect[r][k] = CHIP_ID_EXPECTED;
                OPCODE_REG_WRITE: begin
                    if (k == 0) begin
                        pointer = next_ops[0][2:0];
                    end else begin
                        model_regs[pointer] = next_ops[k];
                        pointer = pointer + reg_addr_t'(1);
                    end
                end
                OPCODE_REG_READ: begin
                    // Nothing on the address byte, then the bank from the pointer on
                    if (k == 0) begin
                        pointer = next_ops[0][2:0];
                    end else begin
                        row_expect[r][k] = model_regs[pointer];
                        pointer = pointer + reg_addr_t'(1);
                    end
                end
                OPCODE_CHECKSUM_FEED: model_sum = model_sum + next_ops[k];
                OPCODE_CHECKSUM_READ: row_expect[r][k] = model_sum;
                default: row_expect[r][k] = '0;
            endcase
        end
        // Read clears the sum once select rises
        if (opcode == OPCODE_CHECKSUM_READ) begin
            model_sum = '0;
        end
        // Twice the bit time of the row plus select, gap and reset slack
        cycle_limit += 2 * ((count + 1) * 8 * 2 * HALF_PERIOD + 2 * HALF_PERIOD +
                            GAP_CYCLES + RESET_CYCLES + 2);
        row_total++;
    endtask

    task automatic build_table();
        random_ops(0);
        add_row("chip_id", OPCODE_CHIP_ID, 3, 1'b0);
        // Six data bytes from address 5, wrapping to 2
        random_ops(1);
        next_ops[0] = 8'h05;
        add_row("reg_write_wrap", OPCODE_REG_WRITE, 7, 1'b0);
        random_ops(0);
        add_row("checksum_feed_5", OPCODE_CHECKSUM_FEED, 5, 1'b0);
        random_ops(0);
        add_row("checksum_feed_3", OPCODE_CHECKSUM_FEED, 3, 1'b0);
        // Must touch neither the bank nor the sum
        random_ops(0);
        add_row("unknown_opcode", 8'h55, 4, 1'b0);
        random_ops(1);
        next_ops[0] = 8'h05;
        add_row("reg_read_from_5", OPCODE_REG_READ, 9, 1'b0);
        next_ops[0] = 8'h02;
        add_row("reg_read_from_2", OPCODE_REG_READ, 9, 1'b0);
        add_row("checksum_read", OPCODE_CHECKSUM_READ, 4, 1'b0);
        add_row("checksum_read_cleared", OPCODE_CHECKSUM_READ, 2, 1'b0);
        // Nonzero sum and bank, then reset ahead of the next row
        random_ops(0);
        add_row("checksum_feed_pre_reset", OPCODE_CHECKSUM_FEED, 4, 1'b0);
        next_ops[0] = 8'h00;
        add_row("reg_read_after_reset", OPCODE_REG_READ, 9, 1'b1);
        add_row("checksum_read_after_reset", OPCODE_CHECKSUM_READ, 3, 1'b0);
    endtask

    task automatic apply_reset();
        @(posedge clock_in);
        reset_n_in <= 1'b0;
        repeat (RESET_CYCLES) @(posedge clock_in);
        reset_n_in <= 1'b1;
    endtask

    // One SPI bit, entered and left on a clock_in edge with the SPI clock low
    task automatic shift_bit(input logic mosi, output logic miso);
        spi_data_in <= mosi;
        repeat (HALF_PERIOD) @(posedge clock_in);
        // Line was set at the last falling SPI edge
        miso = spi_data_out;
        spi_clock_in <= 1'b1;
        repeat (HALF_PERIOD) @(posedge clock_in);
        spi_clock_in <= 1'b0;
    endtask

    task automatic run_transaction(input int r);
        byte_t rx;
        logic  miso;
        @(posedge clock_in);
        spi_select_in <= 1'b0;
        repeat (HALF_PERIOD) @(posedge clock_in);
        for (int b = 7; b >= 0; b--) begin
            shift_bit(row_opcode[r][b], miso);
            rx[b] = miso;
        end
        // Line stays low while the opcode is shifted in
        check_byte($sformatf("%s opcode phase", row_name[r]), 8'h00, rx);
        for (int k = 0; k < row_count[r]; k++) begin
            for (int b = 7; b >= 0; b--) begin
                shift_bit(row_ops[r][k][b], miso);
                rx[b] = miso;
            end
            check_byte($sformatf("%s operand %0d", row_name[r], k + 1), row_expect[r][k], rx);
        end
        repeat (HALF_PERIOD) @(posedge clock_in);
        spi_select_in <= 1'b1;
        spi_data_in   <= 1'b0;
        repeat (GAP_CYCLES) @(posedge clock_in);
    endtask

    initial begin
        reset_n_in    <= 1'b0;
        spi_select_in <= 1'b1;
        spi_clock_in  <= 1'b0;
        spi_data_in   <= 1'b0;
        void'($urandom(RANDOM_SEED));
        clear_model();
        build_table();
        apply_reset();
        for (int r = 0; r < row_total; r++) begin
            if (row_reset[r]) begin
                apply_reset();
            end
            run_transaction(r);
        end
        if (dut_i.checker_i.failure_count == 0) begin
            $display("TEST PASSED");
            $finish;
        end else begin
            $display("Checker assertions failed %0d times", dut_i.checker_i.failure_count);
            $display("TEST FAILED");
            $fatal(1, "Assertion failures in the checker");
        end
    end

endmodule

//--- src/checksum_unit.sv
/*
 * Checksum unit
 * Modulo-256 sum of fed operands
 * Read out during a read transaction and cleared at its end
 */

`timescale 1ns/1ps

module checksum_unit (
    input  logic           clock_in,
    input  logic           reset_n_in,
    input  spi_pkg::byte_t operand,
    input  logic           operand_valid,
    input  logic           checksum_feed_active,
    input  logic           checksum_read_active,
    output spi_pkg::byte_t response_3,
    output logic           response_3_valid
);

    import spi_pkg::*;

    byte_t sum;
    logic  read_active_d;

    always_ff @(posedge clock_in) begin
        if (!reset_n_in) begin
            sum           <= '0;
            read_active_d <= 1'b0;
        end else begin
            read_active_d <= checksum_read_active;

            if (read_active_d && !checksum_read_active) begin
                // Read transaction just ended
                sum <= '0;
            end else if (checksum_feed_active && operand_valid) begin
                // Carry out of bit 7 is dropped
                sum <= sum + operand;
            end
        end
    end

    // Same sum on every operand of the read
    assign response_3       = sum;
    assign response_3_valid = checksum_read_active;

endmodule

//--- src/command_decoder.sv
/*
 * Command decoder
 * Latches the opcode class per transaction
 * Answers the chip ID opcode and enables the sub-peripherals
 */

`timescale 1ns/1ps

module command_decoder (
    input  logic           clock_in,
    input  logic           reset_n_in,
    input  spi_pkg::byte_t opcode,
    input  logic           opcode_valid,
    output spi_pkg::byte_t response_1,
    output logic           response_1_valid,
    output logic           reg_write_active,
    output logic           reg_read_active,
    output logic           checksum_feed_active,
    output logic           checksum_read_active
);

    import spi_pkg::*;

    decoder_state_t state;

    always_ff @(posedge clock_in) begin
        if (!reset_n_in) begin
            state <= IDLE;
        end else begin
            case (state)
                IDLE: begin
                    // Class is chosen once, when the opcode arrives
                    if (opcode_valid) begin
                        case (opcode)
                            OPCODE_CHIP_ID:       state <= CHIP_ID;
                            OPCODE_REG_WRITE:     state <= REG_WRITE;
                            OPCODE_REG_READ:      state <= REG_READ;
                            OPCODE_CHECKSUM_FEED: state <= CHECKSUM_FEED;
                            OPCODE_CHECKSUM_READ: state <= CHECKSUM_READ;
                            default:              state <= UNKNOWN;
                        endcase
                    end
                end
                default: begin
                    // Held until the peripheral drops the opcode at select rise
                    if (!opcode_valid) begin
                        state <= IDLE;
                    end
                end
            endcase
        end
    end

    // Chip ID is answered here directly
    assign response_1       = (state == CHIP_ID) ? CHIP_ID_VALUE : '0;
    assign response_1_valid = (state == CHIP_ID);

    // One enable per sub-peripheral operation, UNKNOWN enables nothing
    assign reg_write_active     = (state == REG_WRITE);
    assign reg_read_active      = (state == REG_READ);
    assign checksum_feed_active = (state == CHECKSUM_FEED);
    assign checksum_read_active = (state == CHECKSUM_READ);

endmodule

//--- src/register_file.sv
/*
 * Eight-byte register bank
 * First operand loads the pointer
 * Burst write and burst read with auto-increment
 */

`timescale 1ns/1ps

module register_file (
    input  logic            clock_in,
    input  logic            reset_n_in,
    input  spi_pkg::byte_t  operand,
    input  logic            operand_valid,
    input  spi_pkg::count_t operand_count,
    input  logic            reg_write_active,
    input  logic            reg_read_active,
    output spi_pkg::byte_t  response_2,
    output logic            response_2_valid
);

    import spi_pkg::*;

    byte_t     regs [REG_COUNT];
    reg_addr_t pointer;
    logic      pointer_loaded;
    logic      active;

    // Either burst direction owns the bank for this transaction
    assign active = reg_write_active | reg_read_active;

    always_ff @(posedge clock_in) begin
        if (!reset_n_in) begin
            for (int i = 0; i < REG_COUNT; i++) begin
                regs[i] <= '0;
            end
            pointer        <= '0;
            pointer_loaded <= 1'b0;
        end else if (!active) begin
            // Next transaction must load the pointer again
            pointer_loaded <= 1'b0;
        end else if (operand_valid) begin
            if (operand_count == count_t'(1)) begin
                // Address byte, upper bits ignored
                pointer        <= operand[2:0];
                pointer_loaded <= 1'b1;
            end else if (pointer_loaded) begin
                if (reg_write_active) begin
                    regs[pointer] <= operand;
                end
                // wraps past 7 back to 0
                pointer <= pointer + reg_addr_t'(1);
            end
        end
    end

    // Read data follows the pointer, nothing before the address byte
    assign response_2       = regs[pointer];
    assign response_2_valid = reg_read_active & pointer_loaded;

endmodule

//--- src/spi_peripheral.sv
/*
 * SPI peripheral, mode 0, master paced
 * Bit capture of opcode and operands in the SPI domain
 * Two-stage synchronisers for the byte flags and the select
 * Response selection and MSB-first shift-out
 */

`timescale 1ns/1ps

module spi_peripheral (
    input  logic            clock_in,
    input  logic            reset_n_in,

    // External SPI pins
    input  logic            spi_select_in,
    input  logic            spi_clock_in,
    input  logic            spi_data_in,
    output logic            spi_data_out,

    // Toward the decoder and the sub-peripherals
    output spi_pkg::byte_t  opcode,
    output spi_pkg::byte_t  operand,
    output logic            opcode_valid,
    output logic            operand_valid,
    output spi_pkg::count_t operand_count,

    // Responses back from the sub-peripherals
    input  spi_pkg::byte_t  response_1,
    input  spi_pkg::byte_t  response_2,
    input  spi_pkg::byte_t  response_3,
    input  logic            response_1_valid,
    input  logic            response_2_valid,
    input  logic            response_3_valid
);

    import spi_pkg::*;

    // SPI clock qualified by select, a rising select also clocks the reset branch
    logic spi_edge;
    assign spi_edge = spi_clock_in | spi_select_in;

    // SPI domain state, cleared by select
    logic [3:0] spi_bit_index     = 4'd15;
    byte_t      spi_opcode;
    byte_t      spi_operand;
    logic       spi_opcode_flag   = 1'b0;
    logic       spi_operand_flag  = 1'b0;
    count_t     spi_operand_count = '0;
    logic       spi_data_q        = 1'b0;

    // Byte captured in the clock_in domain, shifted out on falling edges
    byte_t response_reg;

    // Synchroniser stages
    logic select_meta;
    logic select_sync;
    logic opcode_meta;
    logic opcode_sync;
    logic operand_meta;
    logic operand_sync;
    logic operand_sync_d;
    logic operand_rise;

    always_ff @(posedge spi_edge) begin
        if (spi_select_in) begin
            spi_bit_index     <= 4'd15;
            spi_opcode        <= '0;
            spi_operand       <= '0;
            spi_opcode_flag   <= 1'b0;
            spi_operand_flag  <= 1'b0;
            spi_operand_count <= '0;
        end else begin
            // 15 down to 0 for opcode plus first operand, then 7 down to 0 per operand
            if (spi_bit_index != 4'd0) begin
                spi_bit_index <= spi_bit_index - 4'd1;
            end else begin
                spi_bit_index <= 4'd7;
                // Count holds at 255
                if (spi_operand_count != '1) begin
                    spi_operand_count <= spi_operand_count + count_t'(1);
                end
            end

            // Upper half of the index addresses the opcode bits
            if (spi_bit_index > 4'd7) begin
                spi_opcode[spi_bit_index[2:0]] <= spi_data_in;
            end else begin
                spi_operand[spi_bit_index[2:0]] <= spi_data_in;
            end

            // Opcode flag stays up for the rest of the transaction
            if (spi_bit_index == 4'd8) begin
                spi_opcode_flag <= 1'b1;
            end

            // Operand flag is high for one SPI period after each byte
            spi_operand_flag <= (spi_bit_index == 4'd0);
        end
    end

    // Output bit changes on the falling edge, 0 during the opcode byte
    always_ff @(negedge spi_edge) begin
        if (spi_bit_index < 4'd8) begin
            spi_data_q <= response_reg[spi_bit_index[2:0]];
        end else begin
            spi_data_q <= 1'b0;
        end
    end

    // Line is quiet while deselected
    assign spi_data_out = spi_data_q & ~spi_select_in;

    // First clock_in cycle of a synchronised operand flag
    assign operand_rise = operand_sync & ~operand_sync_d;

    always_ff @(posedge clock_in) begin
        if (!reset_n_in) begin
            select_meta    <= 1'b1;
            select_sync    <= 1'b1;
            opcode_meta    <= 1'b0;
            opcode_sync    <= 1'b0;
            operand_meta   <= 1'b0;
            operand_sync   <= 1'b0;
            operand_sync_d <= 1'b0;
            opcode         <= '0;
            operand        <= '0;
            opcode_valid   <= 1'b0;
            operand_valid  <= 1'b0;
            operand_count  <= '0;
            response_reg   <= '0;
        end else begin
            // Two flops per crossing flag
            select_meta    <= spi_select_in;
            select_sync    <= select_meta;
            opcode_meta    <= spi_opcode_flag;
            opcode_sync    <= opcode_meta;
            operand_meta   <= spi_operand_flag;
            operand_sync   <= operand_meta;
            operand_sync_d <= operand_sync;

            if (select_sync) begin
                // Transaction over, nothing valid until the next opcode
                opcode_valid  <= 1'b0;
                operand_valid <= 1'b0;
            end else begin
                opcode_valid <= opcode_sync;
                // Take the opcode once, SPI side may clear it at select rise
                if (opcode_sync && !opcode_valid) begin
                    opcode <= spi_opcode;
                end

                operand_valid <= operand_rise;
                if (operand_rise) begin
                    operand       <= spi_operand;
                    operand_count <= spi_operand_count;
                end
            end

            // Settled long before the next falling SPI edge, no crossing needed
            case ({response_1_valid, response_2_valid, response_3_valid})
                3'b100:  response_reg <= response_1;
                3'b010:  response_reg <= response_2;
                3'b001:  response_reg <= response_3;
                default: response_reg <= '0;
            endcase
        end
    end

endmodule

//--- src/spi_pkg.sv
/*
 * Shared definitions for the SPI command subsystem
 * Byte, operand count and register index types
 * Opcode and chip ID constants, decoder state encoding
 */

package spi_pkg;

    // Opcode, operand and response bytes
    typedef logic [7:0] byte_t;

    // Operand index within a transaction, saturates at 255
    typedef logic [7:0] count_t;

    // Register index, wraps modulo 8
    typedef logic [2:0] reg_addr_t;

    // Size of the register bank
    localparam int REG_COUNT = 8;

    // Opcodes understood by the decoder
    localparam byte_t OPCODE_CHIP_ID       = 8'hDB;
    localparam byte_t OPCODE_REG_WRITE     = 8'h20;
    localparam byte_t OPCODE_REG_READ      = 8'h21;
    localparam byte_t OPCODE_CHECKSUM_FEED = 8'h30;
    localparam byte_t OPCODE_CHECKSUM_READ = 8'h31;

    // Returned on every operand of a chip ID transaction
    localparam byte_t CHIP_ID_VALUE = 8'h81;

    // Opcode class held by the decoder for one transaction
    typedef enum logic [2:0] {
        IDLE,
        CHIP_ID,
        REG_WRITE,
        REG_READ,
        CHECKSUM_FEED,
        CHECKSUM_READ,
        UNKNOWN
    } decoder_state_t;

endpackage

//--- src/spi_subsystem_top.sv
/*
 * SPI command subsystem top level
 * Peripheral, command decoder, register file and checksum unit
 */

`timescale 1ns/1ps

module spi_subsystem_top (
    input  logic clock_in,
    input  logic reset_n_in,
    input  logic spi_select_in,
    input  logic spi_clock_in,
    input  logic spi_data_in,
    output logic spi_data_out
);

    import spi_pkg::*;

    // Received bytes from the peripheral
    byte_t  opcode;
    byte_t  operand;
    logic   opcode_valid;
    logic   operand_valid;
    count_t operand_count;

    // Responses, at most one valid at a time
    byte_t response_1;
    byte_t response_2;
    byte_t response_3;
    logic  response_1_valid;
    logic  response_2_valid;
    logic  response_3_valid;

    // Decoder enables
    logic reg_write_active;
    logic reg_read_active;
    logic checksum_feed_active;
    logic checksum_read_active;

    spi_peripheral peripheral_i (
        .clock_in         (clock_in),
        .reset_n_in       (reset_n_in),
        .spi_select_in    (spi_select_in),
        .spi_clock_in     (spi_clock_in),
        .spi_data_in      (spi_data_in),
        .spi_data_out     (spi_data_out),
        .opcode           (opcode),
        .operand          (operand),
        .opcode_valid     (opcode_valid),
        .operand_valid    (operand_valid),
        .operand_count    (operand_count),
        .response_1       (response_1),
        .response_2       (response_2),
        .response_3       (response_3),
        .response_1_valid (response_1_valid),
        .response_2_valid (response_2_valid),
        .response_3_valid (response_3_valid)
    );

    command_decoder decoder_i (
        .clock_in             (clock_in),
        .reset_n_in           (reset_n_in),
        .opcode               (opcode),
        .opcode_valid         (opcode_valid),
        .response_1           (response_1),
        .response_1_valid     (response_1_valid),
        .reg_write_active     (reg_write_active),
        .reg_read_active      (reg_read_active),
        .checksum_feed_active (checksum_feed_active),
        .checksum_read_active (checksum_read_active)
    );

    register_file register_file_i (
        .clock_in         (clock_in),
        .reset_n_in       (reset_n_in),
        .operand          (operand),
        .operand_valid    (operand_valid),
        .operand_count    (operand_count),
        .reg_write_active (reg_write_active),
        .reg_read_active  (reg_read_active),
        .response_2       (response_2),
        .response_2_valid (response_2_valid)
    );

    checksum_unit checksum_i (
        .clock_in             (clock_in),
        .reset_n_in           (reset_n_in),
        .operand              (operand),
        .operand_valid        (operand_valid),
        .checksum_feed_active (checksum_feed_active),
        .checksum_read_active (checksum_read_active),
        .response_3           (response_3),
        .response_3_valid     (response_3_valid)
    );

endmodule
